// ==== tile_top.f ====
logic/tile_pkg.sv
logic/tile_control.sv
logic/tile_counters.sv
logic/weight_rom.sv
logic/mac_array.sv
logic/result_writer.sv
logic/tile_top.sv
tb/tb_tile_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tile_top \
	-f tile_top.f -o tb_tile_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_tile_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTS PASSED" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

// ==== weights.hex ====
03
11
7f
2a
ff
05
10
01
c8
44
09
e3
80
fe
21
06
5b
0c
77
02
9d
3e
14
b0

// ==== tb/tb_tile_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tile_top import tile_pkg::*; ();

	localparam int NUM_JOBS = 3;
	localparam int NUM_PASSES = NUM_JOBS * PASS_COUNT;
	localparam int NUM_OPERANDS = NUM_PASSES * ITER_COUNT;
	localparam int NUM_WRITES = NUM_PASSES * TILE_SIZE;
	localparam int JOB_WRITES = PASS_COUNT * TILE_SIZE;
	// A job with random stalls runs for about 80 cycles.
	localparam int JOB_CYCLES = 80;
	localparam int CYCLE_LIMIT = 2 * NUM_JOBS * JOB_CYCLES + 120;

	logic clk_i = 1'b0;
	logic rst_i = 1'b1;
	logic data_available_i = 1'b0;
	logic pipeline_lock_i = 1'b0;
	logic ram_full_i = 1'b0;
	operand_t operand_i = '0;
	logic ram_rd_o, ram_wr_o, idle_o;
	res_write_t res_write_o;

	integer seed;
	operand_t stream [NUM_OPERANDS];
	weight_t weights [WEIGHT_DEPTH];
	acc_t expected [NUM_WRITES];
	acc_t exp_data;
	int op_idx, wr_total, rd_in_pass, wr_run, cycles;
	int errors, tests_run, tests_failed;
	logic read_q, in_wait;
	string test_name;

	always #4 clk_i = ~clk_i;

	tile_top u_dut (
		.clk_i(clk_i), .rst_i(rst_i),
		.data_available_i(data_available_i), .pipeline_lock_i(pipeline_lock_i),
		.operand_i(operand_i), .ram_full_i(ram_full_i),
		.ram_rd_o(ram_rd_o), .ram_wr_o(ram_wr_o),
		.res_write_o(res_write_o), .idle_o(idle_o)
	);

	task automatic log_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// Input memory with one cycle of read latency. Between reads the bus carries junk.
	always @(negedge clk_i) begin
		pipeline_lock_i <= ($random(seed) & 3) == 0;
		ram_full_i <= ($random(seed) & 1) == 1;
		if (read_q) begin
			operand_i <= stream[op_idx];
			op_idx <= op_idx + 1;
		end else begin
			operand_i <= operand_t'($random(seed));
		end
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (rst_i) begin
			read_q <= 1'b0;
			in_wait <= 1'b0;
		end else begin
			read_q <= ram_rd_o;
			if (ram_wr_o)
				rd_in_pass <= 0;
			else if (ram_rd_o)
				rd_in_pass <= rd_in_pass + 1;
			wr_run <= ram_wr_o ? wr_run + 1 : 0;
			if (ram_wr_o)
				wr_total <= wr_total + 1;
			// The last write of a job moves the tile into WAIT.
			if (ram_wr_o && wr_total % JOB_WRITES == JOB_WRITES - 1)
				in_wait <= 1'b1;
			else if (in_wait && !ram_full_i)
				in_wait <= 1'b0;
		end
	end

	always_comb begin
		if (wr_total < NUM_WRITES)
			exp_data = expected[wr_total];
		else
			exp_data = '0;
	end

	assert property (@(posedge clk_i) $fell(rst_i) |=> idle_o)
		else log_error("idle_o did not rise in the second cycle after reset");
	assert property (@(posedge clk_i) disable iff (rst_i) idle_o |-> !ram_rd_o && !ram_wr_o)
		else log_error("read or write strobe while the tile is idle");
	assert property (@(posedge clk_i) disable iff (rst_i) ram_rd_o |-> !pipeline_lock_i)
		else log_error("read strobe while pipeline_lock_i is high");
	assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(ram_wr_o) |-> rd_in_pass == ITER_COUNT)
		else log_error($sformatf("ERR %s: reads per pass expected %0d, got %0d",
			test_name, ITER_COUNT, $sampled(rd_in_pass)));
	assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(ram_wr_o) |-> wr_run == TILE_SIZE)
		else log_error($sformatf("ERR %s: writes per pass expected %0d, got %0d",
			test_name, TILE_SIZE, $sampled(wr_run)));
	assert property (@(posedge clk_i) disable iff (rst_i)
		ram_wr_o |-> res_write_o.addr == res_addr_t'(wr_total))
		else log_error($sformatf("ERR %s: write address expected %0d, got %0d",
			test_name, $sampled(res_addr_t'(wr_total)), $sampled(res_write_o.addr)));
	assert property (@(posedge clk_i) disable iff (rst_i) ram_wr_o |-> res_write_o.data == exp_data)
		else log_error($sformatf("ERR %s: write data expected %0d, got %0d",
			test_name, $sampled(exp_data), $sampled(res_write_o.data)));
	assert property (@(posedge clk_i) disable iff (rst_i) in_wait |-> !ram_rd_o && !ram_wr_o)
		else log_error("read or write strobe while the tile waits on a full result memory");
	assert property (@(posedge clk_i) disable iff (rst_i) in_wait && !ram_full_i |=> idle_o)
		else log_error("tile did not return to idle after ram_full_i fell");

	// Dot product of each pass's operands with each unit's weights.
	task automatic build_reference();
		int sum;
		for (int i = 0; i < NUM_OPERANDS; i++)
			stream[i] = operand_t'($random(seed));
		$readmemh("weights.hex", weights);
		for (int p = 0; p < NUM_PASSES; p++) begin
			for (int u = 0; u < TILE_SIZE; u++) begin
				sum = 0;
				for (int k = 0; k < ITER_COUNT; k++)
					sum += int'(stream[p * ITER_COUNT + k]) * int'(weights[u * ITER_COUNT + k]);
				expected[p * TILE_SIZE + u] = acc_t'(sum);
			end
		end
	endtask

	task automatic wait_idle();
		@(negedge clk_i);
		while (!idle_o)
			@(negedge clk_i);
		@(negedge clk_i);
	endtask

	task automatic report_test(input int errors_before);
		tests_run++;
		if (errors != errors_before) begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, errors - errors_before);
		end else begin
			$display("%s: ok", test_name);
		end
	endtask

	task automatic run_job(input int job);
		int errors_before;
		errors_before = errors;
		test_name = $sformatf("job %0d", job);
		repeat (2) @(negedge clk_i);
		data_available_i <= 1'b1;
		@(negedge clk_i);
		data_available_i <= 1'b0;
		wait_idle();
		report_test(errors_before);
	endtask

	initial begin
		while (cycles < CYCLE_LIMIT)
			@(posedge clk_i);
		$display("Timeout after %0d cycles, the tile stopped making progress", CYCLE_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int errors_before;
		seed = 32'h9abd;
		build_reference();
		test_name = "reset";
		errors_before = errors;
		repeat (3) @(negedge clk_i);
		rst_i <= 1'b0;
		wait_idle();
		report_test(errors_before);
		for (int j = 0; j < NUM_JOBS; j++)
			run_job(j);
		test_name = "totals";
		errors_before = errors;
		assert (wr_total == NUM_WRITES && op_idx == NUM_OPERANDS)
			else log_error($sformatf("ERR %s: writes and reads expected %0d %0d, got %0d %0d",
				test_name, NUM_WRITES, NUM_OPERANDS, wr_total, op_idx));
		report_test(errors_before);
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/tile_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_top import tile_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       data_available_i,
	input  logic       pipeline_lock_i,
	input  operand_t   operand_i,
	input  logic       ram_full_i,
	output logic       ram_rd_o,
	output logic       ram_wr_o,
	output res_write_t res_write_o,
	output logic       idle_o
);

	logic en, unit_rst;
	logic iter_inc, iter_clr, pass_inc, pass_clr, sel_inc, sel_clr;
	logic iter_last, iter_done, sel_last, pass_last;
	unit_sel_t sel;
	iter_t idx;
	weight_t [TILE_SIZE-1:0] weight;
	acc_t [TILE_SIZE-1:0] acc;

	tile_control u_control (
		.clk_i(clk_i), .rst_i(rst_i),
		.data_available_i(data_available_i), .pipeline_lock_i(pipeline_lock_i),
		.ram_full_i(ram_full_i),
		.iter_last_i(iter_last), .iter_done_i(iter_done),
		.sel_last_i(sel_last), .pass_last_i(pass_last),
		.ram_rd_o(ram_rd_o), .en_o(en), .ram_wr_o(ram_wr_o), .unit_rst_o(unit_rst),
		.iter_inc_o(iter_inc), .iter_clr_o(iter_clr),
		.pass_inc_o(pass_inc), .pass_clr_o(pass_clr),
		.sel_inc_o(sel_inc), .sel_clr_o(sel_clr),
		.idle_o(idle_o)
	);

	tile_counters u_counters (
		.clk_i(clk_i), .rst_i(rst_i),
		.iter_inc_i(iter_inc), .iter_clr_i(iter_clr),
		.pass_inc_i(pass_inc), .pass_clr_i(pass_clr),
		.sel_inc_i(sel_inc), .sel_clr_i(sel_clr),
		.iter_last_o(iter_last), .iter_done_o(iter_done),
		.sel_last_o(sel_last), .pass_last_o(pass_last),
		.sel_o(sel)
	);

	weight_rom u_weights (.clk_i(clk_i), .idx_i(idx), .weight_o(weight));

	mac_array u_macs (
		.clk_i(clk_i), .rst_i(rst_i), .en_i(en), .unit_rst_i(unit_rst),
		.operand_i(operand_i), .weight_i(weight), .idx_o(idx), .acc_o(acc)
	);

	result_writer u_writer (
		.clk_i(clk_i), .rst_i(rst_i), .wr_i(ram_wr_o),
		.sel_i(sel), .acc_i(acc), .write_o(res_write_o)
	);

endmodule

`default_nettype wire

// ==== logic/result_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writer import tile_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 wr_i,
	input  unit_sel_t            sel_i,
	input  acc_t [TILE_SIZE-1:0] acc_i,
	output res_write_t           write_o
);

	res_addr_t addr_q;

	// Results of later jobs follow the earlier ones, so only reset returns to zero.
	always_ff @(posedge clk_i) begin
		if (rst_i)
			addr_q <= '0;
		else if (wr_i)
			addr_q <= addr_q + 1'b1;
	end

	always_comb begin
		write_o.addr = addr_q;
		write_o.data = acc_i[sel_i];
	end

endmodule

`default_nettype wire

// ==== logic/mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_array import tile_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    en_i,
	input  logic                    unit_rst_i,
	input  operand_t                operand_i,
	input  weight_t [TILE_SIZE-1:0] weight_i,
	output iter_t                   idx_o,
	output acc_t [TILE_SIZE-1:0]    acc_o
);

	iter_t idx_q;
	acc_t [TILE_SIZE-1:0] acc_q;

	// The index names the operand that arrives with the next enable.
	always_ff @(posedge clk_i) begin
		if (rst_i || unit_rst_i)
			idx_q <= '0;
		else if (en_i)
			idx_q <= idx_q + 1'b1;
	end

	always_ff @(posedge clk_i) begin
		for (int u = 0; u < TILE_SIZE; u++) begin
			if (rst_i || unit_rst_i)
				acc_q[u] <= '0;
			else if (en_i)
				acc_q[u] <= acc_q[u] + acc_t'(operand_i) * acc_t'(weight_i[u]);
		end
	end

	assign idx_o = idx_q;
	assign acc_o = acc_q;

	// More enables than operands per pass would also read past the weight table.
	assert property (@(posedge clk_i) disable iff (rst_i)
		en_i |-> idx_q != iter_t'(ITER_COUNT));

endmodule

`default_nettype wire

// ==== logic/weight_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_rom import tile_pkg::*; (
	input  logic                      clk_i,
	input  iter_t                     idx_i,
	output weight_t [TILE_SIZE-1:0]   weight_o
);

	weight_t rom [WEIGHT_DEPTH];

	initial $readmemh("weights.hex", rom);

	// Unit-major layout. The index rests at ITER_COUNT between passes, so that value reads zero.
	always_comb begin
		for (int u = 0; u < TILE_SIZE; u++) begin
			if (int'(idx_i) < ITER_COUNT)
				weight_o[u] = rom[u * ITER_COUNT + int'(idx_i)];
			else
				weight_o[u] = '0;
		end
	end

	assert property (@(posedge clk_i) int'(idx_i) <= ITER_COUNT);

endmodule

`default_nettype wire

// ==== logic/tile_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_counters import tile_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      iter_inc_i,
	input  logic      iter_clr_i,
	input  logic      pass_inc_i,
	input  logic      pass_clr_i,
	input  logic      sel_inc_i,
	input  logic      sel_clr_i,
	output logic      iter_last_o,
	output logic      iter_done_o,
	output logic      sel_last_o,
	output logic      pass_last_o,
	output unit_sel_t sel_o
);

	iter_t iter_q;
	pass_t pass_q;
	unit_sel_t sel_q;

	always_ff @(posedge clk_i) begin
		if (rst_i || iter_clr_i)
			iter_q <= '0;
		else if (iter_inc_i)
			iter_q <= iter_q + 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i || pass_clr_i)
			pass_q <= '0;
		else if (pass_inc_i)
			pass_q <= pass_q + 1'b1;
	end

	// Clear wins over increment on the last unit.
	always_ff @(posedge clk_i) begin
		if (rst_i || sel_clr_i)
			sel_q <= '0;
		else if (sel_inc_i)
			sel_q <= sel_q + 1'b1;
	end

	assign iter_last_o = (iter_q == iter_t'(ITER_COUNT - 1));
	assign iter_done_o = (iter_q == iter_t'(ITER_COUNT));
	assign sel_last_o = (sel_q == unit_sel_t'(TILE_SIZE - 1));
	// The pass count moves on entry to TRANSFER, so this flags the pass being written.
	assign pass_last_o = (pass_q == pass_t'(PASS_COUNT));
	assign sel_o = sel_q;

	// A step from the last unit must end the walk, so the select never runs past it.
	assert property (@(posedge clk_i) disable iff (rst_i)
		sel_inc_i && sel_last_o |-> sel_clr_i);

endmodule

`default_nettype wire

// ==== logic/tile_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_control import tile_pkg::*; (
	input  logic clk_i,
	input  logic rst_i,
	input  logic data_available_i,
	input  logic pipeline_lock_i,
	input  logic ram_full_i,
	input  logic iter_last_i,
	input  logic iter_done_i,
	input  logic sel_last_i,
	input  logic pass_last_i,
	output logic ram_rd_o,
	output logic en_o,
	output logic ram_wr_o,
	output logic unit_rst_o,
	output logic iter_inc_o,
	output logic iter_clr_o,
	output logic pass_inc_o,
	output logic pass_clr_o,
	output logic sel_inc_o,
	output logic sel_clr_o,
	output logic idle_o
);

	tile_state_e state_q;
	logic process_flag_q;

	assign ram_rd_o = process_flag_q & ~pipeline_lock_i;

	// Only real reads move the operand count, so a lock freezes it.
	assign iter_inc_o = ram_rd_o;
	assign iter_clr_o = (state_q == PROCESS) && iter_done_i;
	assign pass_inc_o = (state_q == PROCESS) && iter_done_i;
	assign sel_inc_o = (state_q == TRANSFER);
	assign sel_clr_o = (state_q == TRANSFER) && sel_last_i;
	assign pass_clr_o = (state_q == TRANSFER) && sel_last_i && pass_last_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= READY;
			process_flag_q <= 1'b0;
			en_o <= 1'b0;
			ram_wr_o <= 1'b0;
			unit_rst_o <= 1'b1;
			idle_o <= 1'b0;
		end else begin
			unit_rst_o <= 1'b0;
			// The input memory answers one cycle after the strobe.
			en_o <= ram_rd_o;
			case (state_q)
				READY: begin
					idle_o <= 1'b1;
					if (data_available_i) begin
						idle_o <= 1'b0;
						process_flag_q <= 1'b1;
						state_q <= PROCESS;
					end
				end
				PROCESS: begin
					if (iter_last_i && ram_rd_o)
						process_flag_q <= 1'b0;
					if (iter_done_i) begin
						ram_wr_o <= 1'b1;
						state_q <= TRANSFER;
					end
				end
				TRANSFER: begin
					if (sel_last_i) begin
						ram_wr_o <= 1'b0;
						unit_rst_o <= 1'b1;
						if (pass_last_i) begin
							state_q <= WAIT;
						end else begin
							process_flag_q <= 1'b1;
							state_q <= PROCESS;
						end
					end
				end
				WAIT: begin
					if (!ram_full_i) begin
						idle_o <= 1'b1;
						state_q <= READY;
					end
				end
				default: state_q <= READY;
			endcase
		end
	end

	assert property (@(posedge clk_i) disable iff (rst_i) !(ram_rd_o && ram_wr_o));

	// A late enable would add a stray operand into the results being written.
	assert property (@(posedge clk_i) disable iff (rst_i) $rose(en_o) |-> state_q == PROCESS);

endmodule

`default_nettype wire

// ==== logic/tile_pkg.sv ====
`default_nettype none

package tile_pkg;

	localparam int TILE_SIZE = 4;
	localparam int PRV_SIZE = 3;
	localparam int PRV_LOOP = 2;
	localparam int ITER_COUNT = PRV_SIZE * PRV_LOOP;
	localparam int PASS_COUNT = 3;
	localparam int WEIGHT_DEPTH = TILE_SIZE * ITER_COUNT;
	localparam int ADDR_W = 8;

	typedef logic [7:0] operand_t;
	typedef logic [7:0] weight_t;
	// Six products of two bytes need 16 + 3 bits; one spare bit is kept.
	typedef logic [19:0] acc_t;
	typedef logic [$clog2(ITER_COUNT + 1)-1:0] iter_t;
	typedef logic [$clog2(TILE_SIZE)-1:0] unit_sel_t;
	typedef logic [$clog2(PASS_COUNT + 1)-1:0] pass_t;
	typedef logic [ADDR_W-1:0] res_addr_t;

	// One-hot state encoding.
	typedef enum logic [3:0] {
		READY    = 4'b0001,
		PROCESS  = 4'b0010,
		TRANSFER = 4'b0100,
		WAIT     = 4'b1000
	} tile_state_e;

	typedef struct packed {
		res_addr_t addr;
		acc_t      data;
	} res_write_t;

endpackage

`default_nettype wire
